// ==== hw/id_pkg.sv ====
package id_pkg;

    typedef logic [31:0] word_t;        // data word, pc or instruction
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] imm16_t;
    typedef logic [11:0] alu_op_t;      // one-hot
    typedef logic [1:0]  imm_ext_t;
    typedef logic [3:0]  br_kind_t;

    // bit positions inside alu_op_t
    localparam int ALU_ADD  = 0,  ALU_SUB  = 1,  ALU_SLT  = 2,  ALU_SLTU = 3,
                   ALU_AND  = 4,  ALU_NOR  = 5,  ALU_OR   = 6,  ALU_XOR  = 7,
                   ALU_SLL  = 8,  ALU_SRL  = 9,  ALU_SRA  = 10, ALU_LUI  = 11;

    localparam imm_ext_t IMM_NONE = 2'b00;  // src2 from rt
    localparam imm_ext_t IMM_ZERO = 2'b01;
    localparam imm_ext_t IMM_SIGN = 2'b10;

    localparam br_kind_t BR_NONE = 4'd0,  BR_BEQ  = 4'd1,  BR_BNE  = 4'd2,
                         BR_BGEZ = 4'd3,  BR_BGTZ = 4'd4,  BR_BLEZ = 4'd5,
                         BR_BLTZ = 4'd6,  BR_J    = 4'd7,  BR_JAL  = 4'd8,
                         BR_JR   = 4'd9,  BR_JALR = 4'd10;

    localparam logic [5:0] OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02,
                           OP_JAL     = 6'h03, OP_BEQ    = 6'h04, OP_BNE   = 6'h05,
                           OP_BLEZ    = 6'h06, OP_BGTZ   = 6'h07, OP_ADDI  = 6'h08,
                           OP_ADDIU   = 6'h09, OP_SLTI   = 6'h0a, OP_SLTIU = 6'h0b,
                           OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e,
                           OP_LUI     = 6'h0f, OP_LW     = 6'h23, OP_SW    = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03,
                           FN_SLLV = 6'h04, FN_SRLV = 6'h06, FN_SRAV = 6'h07,
                           FN_JR   = 6'h08, FN_JALR = 6'h09, FN_ADD  = 6'h20,
                           FN_ADDU = 6'h21, FN_SUB  = 6'h22, FN_SUBU = 6'h23,
                           FN_AND  = 6'h24, FN_OR   = 6'h25, FN_XOR  = 6'h26,
                           FN_NOR  = 6'h27, FN_SLT  = 6'h2a, FN_SLTU = 6'h2b;

    // rt field of the regimm branches
    localparam reg_addr_t RT_BLTZ = 5'h00;
    localparam reg_addr_t RT_BGEZ = 5'h01;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_bus_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_bus_t;

    typedef struct packed {
        reg_addr_t dest;        // 0 when the stage writes nothing
        word_t     result;
    } fwd_src_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      load_op;
        logic      src1_is_sa;
        logic      src1_is_pc;
        imm_ext_t  src2_imm;
        logic      src2_is_8;
        logic      gr_we;
        logic      mem_we;
        reg_addr_t dest;
        logic      uses_rs;
        logic      uses_rt;
        br_kind_t  br_kind;
    } dec_ctrl_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      load_op;
        logic      src1_is_sa;
        logic      src1_is_pc;
        imm_ext_t  src2_imm;
        logic      src2_is_8;
        logic      gr_we;
        logic      mem_we;
        reg_addr_t dest;
        imm16_t    imm;
        word_t     rs_value;
        word_t     rt_value;
        word_t     pc;
    } ds_to_es_bus_t;

    typedef struct packed {
        logic  stall;
        logic  taken;
        word_t target;
    } br_bus_t;

endpackage

// ==== hw/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
    input  logic              clk,
    input  id_pkg::reg_addr_t raddr1,
    input  id_pkg::reg_addr_t raddr2,
    output id_pkg::word_t     rdata1,
    output id_pkg::word_t     rdata2,
    input  id_pkg::wb_bus_t   wb
);
    import id_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (wb.we && (wb.addr != '0)) begin     // r0 is hardwired
            regs[wb.addr] <= wb.data;
        end
    end

    // no write bypass, the wb forward path covers it
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== hw/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder (
    input  id_pkg::word_t     inst,
    output id_pkg::dec_ctrl_t ctrl,
    output id_pkg::imm16_t    imm
);
    import id_pkg::*;

    logic [5:0] op;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [4:0] sa;
    logic [5:0] func;
    logic       special;
    logic       r_alu;          // special with sa field zero
    logic       inst_addu, inst_subu, inst_add, inst_sub, inst_slt, inst_sltu;
    logic       inst_and, inst_or, inst_xor, inst_nor;
    logic       inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
    logic       inst_addiu, inst_addi, inst_slti, inst_sltiu;
    logic       inst_andi, inst_ori, inst_xori, inst_lui;
    logic       inst_lw, inst_sw;
    logic       inst_beq, inst_bne, inst_bgez, inst_bgtz, inst_blez, inst_bltz;
    logic       inst_j, inst_jal, inst_jr, inst_jalr;
    logic       r_ops;          // three-register alu forms
    logic       sa_shift;
    logic       imm_arith;

    assign op      = inst[31:26];
    assign rs      = inst[25:21];
    assign rt      = inst[20:16];
    assign rd      = inst[15:11];
    assign sa      = inst[10:6];
    assign func    = inst[5:0];
    assign imm     = inst[15:0];
    assign special = (op == OP_SPECIAL);
    assign r_alu   = special && (sa == '0);

    assign inst_addu  = r_alu && (func == FN_ADDU);
    assign inst_subu  = r_alu && (func == FN_SUBU);
    assign inst_add   = r_alu && (func == FN_ADD);
    assign inst_sub   = r_alu && (func == FN_SUB);
    assign inst_slt   = r_alu && (func == FN_SLT);
    assign inst_sltu  = r_alu && (func == FN_SLTU);
    assign inst_and   = r_alu && (func == FN_AND);
    assign inst_or    = r_alu && (func == FN_OR);
    assign inst_xor   = r_alu && (func == FN_XOR);
    assign inst_nor   = r_alu && (func == FN_NOR);
    assign inst_sllv  = r_alu && (func == FN_SLLV);
    assign inst_srlv  = r_alu && (func == FN_SRLV);
    assign inst_srav  = r_alu && (func == FN_SRAV);
    assign inst_sll   = special && (rs == '0) && (func == FN_SLL);
    assign inst_srl   = special && (rs == '0) && (func == FN_SRL);
    assign inst_sra   = special && (rs == '0) && (func == FN_SRA);
    assign inst_jr    = r_alu && (func == FN_JR) && (rt == '0) && (rd == '0);
    assign inst_jalr  = r_alu && (func == FN_JALR) && (rt == '0);
    assign inst_addiu = (op == OP_ADDIU);
    assign inst_addi  = (op == OP_ADDI);
    assign inst_slti  = (op == OP_SLTI);
    assign inst_sltiu = (op == OP_SLTIU);
    assign inst_andi  = (op == OP_ANDI);
    assign inst_ori   = (op == OP_ORI);
    assign inst_xori  = (op == OP_XORI);
    assign inst_lui   = (op == OP_LUI) && (rs == '0);
    assign inst_lw    = (op == OP_LW);
    assign inst_sw    = (op == OP_SW);
    assign inst_beq   = (op == OP_BEQ);
    assign inst_bne   = (op == OP_BNE);
    assign inst_blez  = (op == OP_BLEZ) && (rt == '0);
    assign inst_bgtz  = (op == OP_BGTZ) && (rt == '0);
    assign inst_bltz  = (op == OP_REGIMM) && (rt == RT_BLTZ);
    assign inst_bgez  = (op == OP_REGIMM) && (rt == RT_BGEZ);
    assign inst_j     = (op == OP_J);
    assign inst_jal   = (op == OP_JAL);

    assign r_ops = inst_addu | inst_subu | inst_add | inst_sub | inst_slt | inst_sltu
                 | inst_and | inst_or | inst_xor | inst_nor
                 | inst_sllv | inst_srlv | inst_srav;
    assign sa_shift  = inst_sll | inst_srl | inst_sra;
    assign imm_arith = inst_addiu | inst_addi | inst_slti | inst_sltiu
                     | inst_andi | inst_ori | inst_xori | inst_lui;

    always_comb begin
        ctrl = '0;
        ctrl.alu_op[ALU_ADD]  = inst_addu | inst_add | inst_addiu | inst_addi
                              | inst_lw | inst_sw | inst_jal | inst_jalr;  // link adds pc+8
        ctrl.alu_op[ALU_SUB]  = inst_subu | inst_sub;
        ctrl.alu_op[ALU_SLT]  = inst_slt | inst_slti;
        ctrl.alu_op[ALU_SLTU] = inst_sltu | inst_sltiu;
        ctrl.alu_op[ALU_AND]  = inst_and | inst_andi;
        ctrl.alu_op[ALU_NOR]  = inst_nor;
        ctrl.alu_op[ALU_OR]   = inst_or | inst_ori;
        ctrl.alu_op[ALU_XOR]  = inst_xor | inst_xori;
        ctrl.alu_op[ALU_SLL]  = inst_sll | inst_sllv;
        ctrl.alu_op[ALU_SRL]  = inst_srl | inst_srlv;
        ctrl.alu_op[ALU_SRA]  = inst_sra | inst_srav;
        ctrl.alu_op[ALU_LUI]  = inst_lui;

        ctrl.load_op    = inst_lw;
        ctrl.mem_we     = inst_sw;
        ctrl.src1_is_sa = sa_shift;
        ctrl.src1_is_pc = inst_jal | inst_jalr;
        ctrl.src2_is_8  = inst_jal | inst_jalr;
        ctrl.gr_we      = r_ops | sa_shift | imm_arith | inst_lw | inst_jal | inst_jalr;

        if (inst_andi | inst_ori | inst_xori | inst_lui) begin
            ctrl.src2_imm = IMM_ZERO;
        end else if (inst_addiu | inst_addi | inst_slti | inst_sltiu | inst_lw | inst_sw) begin
            ctrl.src2_imm = IMM_SIGN;
        end

        if (inst_jal) begin
            ctrl.dest = 5'd31;
        end else if (imm_arith | inst_lw) begin
            ctrl.dest = rt;
        end else if (r_ops | sa_shift | inst_jalr) begin
            ctrl.dest = rd;
        end                                             // unknown word stays at 0

        ctrl.uses_rs = r_ops | (imm_arith & ~inst_lui) | inst_lw | inst_sw | inst_beq
                     | inst_bne | inst_bgez | inst_bgtz | inst_blez | inst_bltz
                     | inst_jr | inst_jalr;
        ctrl.uses_rt = r_ops | sa_shift | inst_sw | inst_beq | inst_bne;

        if (inst_beq)       ctrl.br_kind = BR_BEQ;
        else if (inst_bne)  ctrl.br_kind = BR_BNE;
        else if (inst_bgez) ctrl.br_kind = BR_BGEZ;
        else if (inst_bgtz) ctrl.br_kind = BR_BGTZ;
        else if (inst_blez) ctrl.br_kind = BR_BLEZ;
        else if (inst_bltz) ctrl.br_kind = BR_BLTZ;
        else if (inst_j)    ctrl.br_kind = BR_J;
        else if (inst_jal)  ctrl.br_kind = BR_JAL;
        else if (inst_jr)   ctrl.br_kind = BR_JR;
        else if (inst_jalr) ctrl.br_kind = BR_JALR;
    end

    alu_op_onehot: assert final ($onehot0(ctrl.alu_op));

endmodule

// ==== hw/operand_forward.sv ====
`timescale 1ns/100ps

module operand_forward (
    input  logic              clk,
    input  id_pkg::word_t     inst,
    input  id_pkg::dec_ctrl_t ctrl,
    input  id_pkg::wb_bus_t   wb,
    input  id_pkg::fwd_src_t  exe_fwd,
    input  id_pkg::fwd_src_t  mem_fwd,
    input  id_pkg::fwd_src_t  wb_fwd,
    input  logic              es_load_op,
    output id_pkg::word_t     rs_value,
    output id_pkg::word_t     rt_value,
    output logic              load_stall
);
    import id_pkg::*;

    reg_addr_t rs;
    reg_addr_t rt;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    logic      rs_live;         // used and not r0
    logic      rt_live;
    logic      rs_exe, rs_mem, rs_wb;
    logic      rt_exe, rt_mem, rt_wb;

    assign rs = inst[25:21];
    assign rt = inst[20:16];

    reg_file reg_file_inst (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wb     (wb)
    );

    assign rs_live = ctrl.uses_rs && (rs != '0);
    assign rt_live = ctrl.uses_rt && (rt != '0);

    assign rs_exe = rs_live && (rs == exe_fwd.dest);
    assign rs_mem = rs_live && (rs == mem_fwd.dest);
    assign rs_wb  = rs_live && (rs == wb_fwd.dest);
    assign rt_exe = rt_live && (rt == exe_fwd.dest);
    assign rt_mem = rt_live && (rt == mem_fwd.dest);
    assign rt_wb  = rt_live && (rt == wb_fwd.dest);

    // youngest producer wins
    assign rs_value = rs_exe ? exe_fwd.result :
                      rs_mem ? mem_fwd.result :
                      rs_wb  ? wb_fwd.result  : rf_rdata1;
    assign rt_value = rt_exe ? exe_fwd.result :
                      rt_mem ? mem_fwd.result :
                      rt_wb  ? wb_fwd.result  : rf_rdata2;

    // load data not ready until mem
    assign load_stall = es_load_op && (rs_exe || rt_exe);

    // r0 reads zero through both the array and the forward muxes
    r0_not_forwarded: assert property (@(posedge clk)
        ((rs == '0) |-> (rs_value == '0)) and ((rt == '0) |-> (rt_value == '0)));

endmodule

// ==== hw/branch_unit.sv ====
`timescale 1ns/100ps

module branch_unit (
    input  logic             valid,
    input  id_pkg::word_t    pc,
    input  id_pkg::word_t    inst,
    input  id_pkg::br_kind_t br_kind,
    input  id_pkg::word_t    rs_value,
    input  id_pkg::word_t    rt_value,
    input  logic             load_stall,
    output id_pkg::br_bus_t  br_bus
);
    import id_pkg::*;

    word_t pc_plus4;
    word_t cond_target;
    word_t jump_target;
    word_t target;
    logic  rs_eq_rt;
    logic  rs_zero;
    logic  rs_neg;
    logic  cond;
    logic  taken;

    assign pc_plus4    = pc + 32'd4;
    assign cond_target = pc_plus4 + {{14{inst[15]}}, inst[15:0], 2'b00};
    assign jump_target = {pc_plus4[31:28], inst[25:0], 2'b00};  // 256 MB region

    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_zero  = (rs_value == '0);
    assign rs_neg   = rs_value[31];

    always_comb begin
        case (br_kind)
            BR_BEQ:  cond = rs_eq_rt;
            BR_BNE:  cond = !rs_eq_rt;
            BR_BGEZ: cond = !rs_neg;
            BR_BGTZ: cond = !rs_neg && !rs_zero;
            BR_BLEZ: cond = rs_neg || rs_zero;
            BR_BLTZ: cond = rs_neg;
            BR_J, BR_JAL, BR_JR, BR_JALR: cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        case (br_kind)
            BR_J, BR_JAL:   target = jump_target;
            BR_JR, BR_JALR: target = rs_value;
            BR_NONE:        target = pc_plus4;
            default:        target = cond_target;
        endcase
    end

    assign taken  = valid && cond;
    assign br_bus = '{stall: load_stall && taken, taken: taken, target: target};

endmodule

// ==== hw/id_stage.sv ====
`timescale 1ns/100ps

module id_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fs_to_ds_valid,
    input  id_pkg::fetch_bus_t    fs_to_ds_bus,
    output logic                  ds_allowin,
    input  logic                  es_allowin,
    output logic                  ds_to_es_valid,
    output id_pkg::ds_to_es_bus_t ds_to_es_bus,
    input  id_pkg::wb_bus_t       ws_to_rf_bus,
    input  id_pkg::fwd_src_t      exe_fwd,
    input  id_pkg::fwd_src_t      mem_fwd,
    input  id_pkg::fwd_src_t      wb_fwd,
    input  logic                  es_load_op,
    output id_pkg::br_bus_t       br_bus
);
    import id_pkg::*;

    logic       ds_valid;
    logic       ds_ready_go;
    fetch_bus_t fs_bus_r;       // held pc and instruction
    dec_ctrl_t  ctrl;
    imm16_t     imm;
    word_t      rs_value;
    word_t      rt_value;
    logic       load_stall;

    assign ds_ready_go    = !load_stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            fs_bus_r <= fs_to_ds_bus;
        end
    end

    inst_decoder inst_decoder_inst (
        .inst (fs_bus_r.inst),
        .ctrl (ctrl),
        .imm  (imm)
    );

    operand_forward operand_forward_inst (
        .clk        (clk),
        .inst       (fs_bus_r.inst),
        .ctrl       (ctrl),
        .wb         (ws_to_rf_bus),
        .exe_fwd    (exe_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .es_load_op (es_load_op),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .load_stall (load_stall)
    );

    branch_unit branch_unit_inst (
        .valid      (ds_valid),
        .pc         (fs_bus_r.pc),
        .inst       (fs_bus_r.inst),
        .br_kind    (ctrl.br_kind),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .load_stall (load_stall),
        .br_bus     (br_bus)
    );

    assign ds_to_es_bus = '{
        alu_op:     ctrl.alu_op,
        load_op:    ctrl.load_op,
        src1_is_sa: ctrl.src1_is_sa,
        src1_is_pc: ctrl.src1_is_pc,
        src2_imm:   ctrl.src2_imm,
        src2_is_8:  ctrl.src2_is_8,
        gr_we:      ctrl.gr_we,
        mem_we:     ctrl.mem_we,
        dest:       ctrl.dest,
        imm:        imm,
        rs_value:   rs_value,
        rt_value:   rt_value,
        pc:         fs_bus_r.pc
    };

    // output valid only ever comes from an instruction held in the stage
    valid_from_held: assert property (@(posedge clk) disable iff (reset)
        $rose(ds_to_es_valid) |-> ds_valid);

endmodule

// ==== tb/id_tb_tasks.svh ====
`ifndef ID_TB_TASKS_SVH
`define ID_TB_TASKS_SVH

task automatic fail_now(input string msg);
    err_count++;
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
endtask

function automatic word_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic word_t enc_r(input logic [5:0] fn, input reg_addr_t rs, input reg_addr_t rt,
                                input reg_addr_t rd, input logic [4:0] sa);
    return {OP_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rs, input reg_addr_t rt,
                                input imm16_t imm);
    return {op, rs, rt, imm};
endfunction

function automatic word_t enc_j(input logic [5:0] op, input logic [25:0] idx);
    return {op, idx};
endfunction

function automatic alu_op_t alu_bit(input int pos);
    return alu_op_t'(1) << pos;
endfunction

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) fail_now($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) fail_now($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

task automatic check_alu(input string name, input alu_op_t got, input alu_op_t exp);
    if (got !== exp) fail_now($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

task automatic check_ext(input string name, input imm_ext_t got, input imm_ext_t exp);
    if (got !== exp) fail_now($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

// hands one instruction over and returns at the falling edge after the transfer
task automatic send_inst(input word_t w, input word_t pc);
    int n;
    n = 0;
    @(negedge clk);
    fs_to_ds_valid = 1'b1;
    fs_to_ds_bus   = '{pc: pc, inst: w};
    while (!ds_allowin) begin
        if (n == 50) fail_now("instruction was never accepted by the stage");
        n++;
        @(negedge clk);
    end
    @(negedge clk);
    fs_to_ds_valid = 1'b0;
endtask

task automatic write_reg(input reg_addr_t a, input word_t d);
    @(negedge clk);
    ws_to_rf_bus = '{we: 1'b1, addr: a, data: d};
    @(negedge clk);
    ws_to_rf_bus = '0;
endtask

task automatic decode_check(input word_t w, input alu_op_t alu, input imm_ext_t ext,
                            input reg_addr_t dst, input logic we);
    send_inst(w, 32'h0040_0000);
    check_bit("ds_to_es_valid", ds_to_es_valid, 1'b1);
    check_alu("alu_op", ds_to_es_bus.alu_op, alu);
    check_ext("src2_imm", ds_to_es_bus.src2_imm, ext);
    check_addr("dest", ds_to_es_bus.dest, dst);
    check_bit("gr_we", ds_to_es_bus.gr_we, we);
endtask

task automatic test_decode();
    check_bit("ds_to_es_valid", ds_to_es_valid, 1'b0);
    check_bit("br_bus.taken", br_bus.taken, 1'b0);
    check_bit("ds_allowin", ds_allowin, 1'b1);
    decode_check(enc_r(FN_ADDU, 1, 2, 3, 0), alu_bit(ALU_ADD), IMM_NONE, 3, 1);
    decode_check(enc_r(FN_SUBU, 1, 2, 4, 0), alu_bit(ALU_SUB), IMM_NONE, 4, 1);
    decode_check(enc_r(FN_ADD, 1, 2, 5, 0), alu_bit(ALU_ADD), IMM_NONE, 5, 1);
    decode_check(enc_r(FN_SUB, 1, 2, 6, 0), alu_bit(ALU_SUB), IMM_NONE, 6, 1);
    decode_check(enc_r(FN_SLT, 1, 2, 7, 0), alu_bit(ALU_SLT), IMM_NONE, 7, 1);
    decode_check(enc_r(FN_SLTU, 1, 2, 8, 0), alu_bit(ALU_SLTU), IMM_NONE, 8, 1);
    decode_check(enc_r(FN_AND, 1, 2, 9, 0), alu_bit(ALU_AND), IMM_NONE, 9, 1);
    decode_check(enc_r(FN_OR, 1, 2, 10, 0), alu_bit(ALU_OR), IMM_NONE, 10, 1);
    decode_check(enc_r(FN_XOR, 1, 2, 11, 0), alu_bit(ALU_XOR), IMM_NONE, 11, 1);
    decode_check(enc_r(FN_NOR, 1, 2, 12, 0), alu_bit(ALU_NOR), IMM_NONE, 12, 1);
    decode_check(enc_r(FN_SLLV, 1, 2, 13, 0), alu_bit(ALU_SLL), IMM_NONE, 13, 1);
    decode_check(enc_r(FN_SRLV, 1, 2, 14, 0), alu_bit(ALU_SRL), IMM_NONE, 14, 1);
    decode_check(enc_r(FN_SRAV, 1, 2, 15, 0), alu_bit(ALU_SRA), IMM_NONE, 15, 1);
    decode_check(enc_r(FN_SLL, 0, 2, 16, 4), alu_bit(ALU_SLL), IMM_NONE, 16, 1);
    check_bit("src1_is_sa", ds_to_es_bus.src1_is_sa, 1'b1);
    decode_check(enc_r(FN_SRL, 0, 2, 17, 4), alu_bit(ALU_SRL), IMM_NONE, 17, 1);
    decode_check(enc_r(FN_SRA, 0, 2, 18, 4), alu_bit(ALU_SRA), IMM_NONE, 18, 1);
    decode_check(enc_i(OP_ADDIU, 1, 19, 16'h8001), alu_bit(ALU_ADD), IMM_SIGN, 19, 1);
    decode_check(enc_i(OP_ADDI, 1, 20, 16'h0004), alu_bit(ALU_ADD), IMM_SIGN, 20, 1);
    decode_check(enc_i(OP_SLTI, 1, 21, 16'hfff0), alu_bit(ALU_SLT), IMM_SIGN, 21, 1);
    decode_check(enc_i(OP_SLTIU, 1, 22, 16'h0010), alu_bit(ALU_SLTU), IMM_SIGN, 22, 1);
    decode_check(enc_i(OP_ANDI, 1, 23, 16'h00ff), alu_bit(ALU_AND), IMM_ZERO, 23, 1);
    decode_check(enc_i(OP_ORI, 1, 24, 16'hf0f0), alu_bit(ALU_OR), IMM_ZERO, 24, 1);
    decode_check(enc_i(OP_XORI, 1, 25, 16'h1234), alu_bit(ALU_XOR), IMM_ZERO, 25, 1);
    decode_check(enc_i(OP_LUI, 0, 26, 16'hbeef), alu_bit(ALU_LUI), IMM_ZERO, 26, 1);
    check_word("imm", word_t'(ds_to_es_bus.imm), 32'h0000_beef);
    decode_check(enc_i(OP_LW, 1, 27, 16'h0008), alu_bit(ALU_ADD), IMM_SIGN, 27, 1);
    check_bit("load_op", ds_to_es_bus.load_op, 1'b1);
    check_bit("mem_we", ds_to_es_bus.mem_we, 1'b0);
    decode_check(enc_i(OP_SW, 1, 27, 16'h000c), alu_bit(ALU_ADD), IMM_SIGN, 0, 0);
    check_bit("mem_we", ds_to_es_bus.mem_we, 1'b1);
    check_bit("load_op", ds_to_es_bus.load_op, 1'b0);
    decode_check(enc_i(6'h3f, 1, 2, 16'h0000), '0, IMM_NONE, 0, 0);   // unknown opcode
    check_bit("mem_we", ds_to_es_bus.mem_we, 1'b0);
endtask

task automatic test_reg_rw();
    word_t v5;
    word_t v6;
    v5 = next_rand();
    v6 = next_rand();
    write_reg(5, v5);
    write_reg(6, v6);
    write_reg(0, next_rand());
    send_inst(enc_r(FN_ADDU, 5, 6, 7, 0), 32'h0040_0100);
    check_word("rs_value", ds_to_es_bus.rs_value, v5);
    check_word("rt_value", ds_to_es_bus.rt_value, v6);
    send_inst(enc_r(FN_ADDU, 0, 5, 7, 0), 32'h0040_0104);
    check_word("rs_value", ds_to_es_bus.rs_value, 32'h0);
    check_word("rt_value", ds_to_es_bus.rt_value, v5);
    write_reg(30, 32'h1357_9bdf);
endtask

task automatic test_forward();
    word_t ve;
    word_t vm;
    word_t vw;
    ve = next_rand();
    vm = next_rand();
    vw = next_rand();
    write_reg(12, 32'h0bad_cafe);
    send_inst(enc_r(FN_ADDU, 12, 30, 7, 0), 32'h0040_0200);
    exe_fwd = '{dest: 12, result: ve};
    mem_fwd = '{dest: 12, result: vm};
    wb_fwd  = '{dest: 12, result: vw};
    #5;
    check_word("rs_value", ds_to_es_bus.rs_value, ve);
    check_word("rt_value", ds_to_es_bus.rt_value, 32'h1357_9bdf);
    @(negedge clk);
    exe_fwd = '0;
    #5;
    check_word("rs_value", ds_to_es_bus.rs_value, vm);
    @(negedge clk);
    mem_fwd = '0;
    #5;
    check_word("rs_value", ds_to_es_bus.rs_value, vw);
    @(negedge clk);
    wb_fwd = '0;
    #5;
    check_word("rs_value", ds_to_es_bus.rs_value, 32'h0bad_cafe);
    // lui reads no register, so a matching rt must come from the array
    @(negedge clk);
    exe_fwd = '{dest: 12, result: ve};
    send_inst(enc_i(OP_LUI, 0, 12, 16'h0001), 32'h0040_0204);
    check_word("rt_value", ds_to_es_bus.rt_value, 32'h0bad_cafe);
    exe_fwd = '0;
endtask

task automatic test_load_use();
    word_t ld;
    int    n;
    ld = next_rand();
    @(negedge clk);
    es_load_op = 1'b1;
    exe_fwd    = '{dest: 5, result: ld};
    send_inst(enc_i(OP_BEQ, 5, 5, 16'h0010), 32'h0040_0300);
    repeat (3) begin
        check_bit("ds_to_es_valid", ds_to_es_valid, 1'b0);
        check_bit("ds_allowin", ds_allowin, 1'b0);
        check_bit("br_bus.taken", br_bus.taken, 1'b1);
        check_bit("br_bus.stall", br_bus.stall, 1'b1);
        @(negedge clk);
    end
    es_load_op = 1'b0;
    n = 0;
    #5;
    while (!ds_to_es_valid) begin
        if (n == 20) fail_now("stalled instruction did not leave after the load cleared");
        n++;
        @(negedge clk);
        #5;
    end
    check_word("rs_value", ds_to_es_bus.rs_value, ld);
    check_bit("br_bus.stall", br_bus.stall, 1'b0);
    @(negedge clk);
    exe_fwd = '0;
endtask

task automatic test_branches();
    word_t         a;
    word_t         b;
    word_t         pc;
    word_t         w;
    word_t         tgt;
    word_t         soff;
    imm16_t        off;
    logic [25:0]   idx;
    logic          tk;
    br_kind_t      k;
    for (int round = 0; round < 3; round++) begin
        for (int kk = 1; kk <= 10; kk++) begin
            k   = br_kind_t'(kk);
            a   = (next_rand() % 4 == 0) ? 32'h0 : next_rand();
            b   = (next_rand() % 2 == 0) ? a : next_rand();
            pc  = next_rand() & 32'hffff_fffc;
            off = imm16_t'(next_rand());
            idx = 26'(next_rand());
            write_reg(8, a);
            write_reg(9, b);
            soff = {{16{off[15]}}, off};
            tgt  = pc + 32'd4 + (soff << 2);
            case (k)
                BR_BEQ: begin
                    w  = enc_i(OP_BEQ, 8, 9, off);
                    tk = (a == b);
                end
                BR_BNE: begin
                    w  = enc_i(OP_BNE, 8, 9, off);
                    tk = (a != b);
                end
                BR_BGEZ: begin
                    w  = enc_i(OP_REGIMM, 8, RT_BGEZ, off);
                    tk = ($signed(a) >= 0);
                end
                BR_BGTZ: begin
                    w  = enc_i(OP_BGTZ, 8, 0, off);
                    tk = ($signed(a) > 0);
                end
                BR_BLEZ: begin
                    w  = enc_i(OP_BLEZ, 8, 0, off);
                    tk = ($signed(a) <= 0);
                end
                BR_BLTZ: begin
                    w  = enc_i(OP_REGIMM, 8, RT_BLTZ, off);
                    tk = ($signed(a) < 0);
                end
                BR_J, BR_JAL: begin
                    w   = enc_j((k == BR_J) ? OP_J : OP_JAL, idx);
                    tk  = 1'b1;
                    tgt = {4'((pc + 32'd4) >> 28), idx, 2'b00};
                end
                BR_JR: begin
                    w   = enc_r(FN_JR, 8, 0, 0, 0);
                    tk  = 1'b1;
                    tgt = a;
                end
                default: begin
                    w   = enc_r(FN_JALR, 8, 0, 31, 0);
                    tk  = 1'b1;
                    tgt = a;
                end
            endcase
            send_inst(w, pc);
            check_bit("br_bus.taken", br_bus.taken, tk);
            if (tk) check_word("br_bus.target", br_bus.target, tgt);
            if (k == BR_JAL) begin
                check_addr("dest", ds_to_es_bus.dest, 5'd31);
                check_bit("src1_is_pc", ds_to_es_bus.src1_is_pc, 1'b1);
                check_bit("src2_is_8", ds_to_es_bus.src2_is_8, 1'b1);
                check_bit("gr_we", ds_to_es_bus.gr_we, 1'b1);
            end
        end
    end
endtask

task automatic test_backpressure();
    ds_to_es_bus_t held;
    @(negedge clk);
    es_allowin = 1'b0;
    send_inst(enc_r(FN_OR, 5, 6, 9, 0), 32'h0040_0400);
    held           = ds_to_es_bus;
    fs_to_ds_valid = 1'b1;
    fs_to_ds_bus   = '{pc: 32'h0040_0404, inst: enc_r(FN_XOR, 5, 6, 10, 0)};
    repeat (3) begin
        @(negedge clk);
        check_bit("ds_allowin", ds_allowin, 1'b0);
        check_bit("ds_to_es_valid", ds_to_es_valid, 1'b1);
        check_bit("ds_to_es_bus stable", ds_to_es_bus == held, 1'b1);
    end
    es_allowin = 1'b1;
    @(negedge clk);
    fs_to_ds_valid = 1'b0;
    check_word("ds_to_es_bus.pc", ds_to_es_bus.pc, 32'h0040_0404);
    check_alu("alu_op", ds_to_es_bus.alu_op, alu_bit(ALU_XOR));
    check_bit("ds_to_es_valid", ds_to_es_valid, 1'b1);
endtask

`endif

// ==== tb/tb_id_stage.sv ====
`timescale 1ns/100ps

module tb_id_stage;
    import id_pkg::*;

    logic          clk;
    logic          reset;
    logic          fs_to_ds_valid;
    fetch_bus_t    fs_to_ds_bus;
    logic          ds_allowin;
    logic          es_allowin;
    logic          ds_to_es_valid;
    ds_to_es_bus_t ds_to_es_bus;
    wb_bus_t       ws_to_rf_bus;
    fwd_src_t      exe_fwd;
    fwd_src_t      mem_fwd;
    fwd_src_t      wb_fwd;
    logic          es_load_op;
    br_bus_t       br_bus;

    word_t         rng_state;
    int            err_count;

    always #10 clk = ~clk;      // 20 ns period

    `include "id_tb_tasks.svh"

    id_stage id_stage_inst (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .ds_allowin     (ds_allowin),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .ws_to_rf_bus   (ws_to_rf_bus),
        .exe_fwd        (exe_fwd),
        .mem_fwd        (mem_fwd),
        .wb_fwd         (wb_fwd),
        .es_load_op     (es_load_op),
        .br_bus         (br_bus)
    );

    // overall watchdog on top of the per-wait limits
    initial begin
        #400000;
        fail_now("simulation ran past its time limit");
    end

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus   = '0;
        es_allowin     = 1'b1;
        ws_to_rf_bus   = '0;
        exe_fwd        = '0;
        mem_fwd        = '0;
        wb_fwd         = '0;
        es_load_op     = 1'b0;
        rng_state      = 32'd19927;
        err_count      = 0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_decode();
        test_reg_rw();
        test_forward();
        test_load_use();
        test_branches();
        test_backpressure();

        repeat (2) @(negedge clk);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+tb
hw/id_pkg.sv
hw/reg_file.sv
hw/inst_decoder.sv
hw/operand_forward.sv
hw/branch_unit.sv
hw/id_stage.sv
tb/tb_id_stage.sv
